// File: src/mac_byte_pkg.sv
`default_nettype none

package mac_byte_pkg;

  ////////////////////////////////////////
  // mac client byte stream
  ////////////////////////////////////////

  localparam int BYTE_W = 8;             // one beat per clk_125 cycle

  // same beat format on rx and tx toward the mac
  typedef struct packed {
    logic [BYTE_W-1:0] data;             // payload byte
    logic              last;             // final byte of frame
  } mac_byte_t;

endpackage

`default_nettype wire

// File: src/client_word_pkg.sv
`default_nettype none

package client_word_pkg;
  import mac_byte_pkg::*;

  ////////////////////////////////////////
  // user side word stream
  ////////////////////////////////////////

  localparam int BYTES_PER_WORD = 8;                   // lanes per word
  localparam int WORD_W         = BYTES_PER_WORD * BYTE_W;  // 64 bit word
  localparam int LANE_W         = $clog2(BYTES_PER_WORD);   // lane index width
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(BYTES_PER_WORD - 1);

  // one word, flat or by byte lane
  typedef union packed {
    logic [WORD_W-1:0]                     flat;  // fifo and top view
    logic [BYTES_PER_WORD-1:0][BYTE_W-1:0] lane;  // lane 0 is first byte
  } client_data_u;

  typedef struct packed {
    client_data_u              data;
    logic [BYTES_PER_WORD-1:0] keep;     // bit i marks lane i
    logic                      last;     // final word of frame
  } client_word_t;

  // packer to frame buffer only
  typedef struct packed {
    client_word_t word;
    logic         error;                 // frame bad, valid with last
  } rx_word_t;

  // keep must be nonzero and filled from lane 0 upward
  function automatic logic keep_contig(logic [BYTES_PER_WORD-1:0] keep);
    logic [BYTES_PER_WORD-1:0] keep_inc;
    keep_inc = keep + 1'b1;
    return (keep != '0) && ((keep & keep_inc) == '0);
  endfunction

endpackage

`default_nettype wire

// File: src/rx_byte_packer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_byte_packer
  import mac_byte_pkg::*, client_word_pkg::*;
(
  input  wire logic      clk_125,
  input  wire logic      rst,
  input  wire logic      rx_byte_valid,   // one strobe per byte, no stall
  input  wire mac_byte_t rx_byte,
  input  wire logic      rx_frame_error,  // only meaningful with last
  output logic           wr_valid,        // one strobe per packed word
  output rx_word_t       wr_word
);

  ////////////////////////////////////////
  // lane assembly
  ////////////////////////////////////////

  logic [LANE_W-1:0]         lane_cnt;    // next lane to fill
  client_data_u              acc_data;    // partial word, empty lanes zero
  logic [BYTES_PER_WORD-1:0] acc_keep;
  client_data_u              nxt_data;    // partial word plus current byte
  logic [BYTES_PER_WORD-1:0] nxt_keep;
  logic                      emit;        // word complete this cycle

  always_comb
  begin
    nxt_data                 = acc_data;
    nxt_keep                 = acc_keep;
    nxt_data.lane[lane_cnt]  = rx_byte.data;  // steer into its lane
    nxt_keep[lane_cnt]       = 1'b1;
    emit = rx_byte_valid && (rx_byte.last || (lane_cnt == LAST_LANE));
  end

  always_ff @(posedge clk_125)
  begin
    if (rst)
    begin
      lane_cnt      <= '0;
      acc_data.flat <= '0;
      acc_keep      <= '0;
      wr_valid      <= 1'b0;
    end
    else
    begin
      wr_valid <= emit;                      // fixed one cycle latency
      if (rx_byte_valid)
      begin
        if (emit)
        begin
          lane_cnt      <= '0;               // wrap or frame end
          acc_data.flat <= '0;               // unkept lanes must read zero
          acc_keep      <= '0;
        end
        else
        begin
          lane_cnt <= lane_cnt + 1'b1;
          acc_data <= nxt_data;
          acc_keep <= nxt_keep;
        end
      end
    end
  end

  // output word register, payload only
  always_ff @(posedge clk_125)
  begin
    if (emit)
    begin
      wr_word.word.data <= nxt_data;
      wr_word.word.keep <= nxt_keep;
      wr_word.word.last <= rx_byte.last;
      wr_word.error     <= rx_byte.last && rx_frame_error;  // tuser style flag
    end
  end

  // every word leaving here obeys the packing rule
  a_keep_contig: assert property (@(posedge clk_125) disable iff (rst)
    wr_valid |-> keep_contig(wr_word.word.keep));

endmodule

`default_nettype wire

// File: src/rx_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_buffer
  import client_word_pkg::*;
#(
  parameter int BUFFER_DEPTH              // word entries, power of two
)
(
  input  wire logic     clk_125,
  input  wire logic     rst,
  input  wire logic     wr_valid,         // strobe from packer
  input  wire rx_word_t wr_word,
  output logic          mac_rx_valid,
  output client_word_t  mac_rx_word,
  input  wire logic     mac_rx_ready
);

  localparam int ADDR_W = $clog2(BUFFER_DEPTH);
  localparam int PTR_W  = ADDR_W + 1;     // extra wrap bit
  localparam logic [PTR_W-1:0] DEPTH_P = PTR_W'(BUFFER_DEPTH);

  ////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////

  client_word_t     mem [BUFFER_DEPTH];   // circular word store
  logic [PTR_W-1:0] rd_ptr;               // head of oldest good frame
  logic [PTR_W-1:0] cmt_ptr;              // end of last committed frame
  logic [PTR_W-1:0] spec_ptr;             // write point of frame in flight
  logic             ovf;                  // current frame lost a word
  logic             full;
  logic             frame_bad;            // rewind instead of commit
  logic             wr_en;
  logic             rd_en;

  assign full      = (spec_ptr - rd_ptr) == DEPTH_P;
  assign frame_bad = ovf || full || wr_word.error;
  assign wr_en     = wr_valid && !full && !ovf;
  assign rd_en     = mac_rx_valid && mac_rx_ready;

  ////////////////////////////////////////
  // write side, commit or rewind
  ////////////////////////////////////////

  always_ff @(posedge clk_125)
  begin
    if (rst)
    begin
      spec_ptr <= '0;
      cmt_ptr  <= '0;
      ovf      <= 1'b0;
    end
    else if (wr_valid)
    begin
      if (wr_word.word.last)
      begin
        ovf <= 1'b0;                      // next frame starts clean
        if (frame_bad)
        begin
          spec_ptr <= cmt_ptr;            // drop whole frame
        end
        else
        begin
          spec_ptr <= spec_ptr + 1'b1;
          cmt_ptr  <= spec_ptr + 1'b1;    // frame now visible
        end
      end
      else if (full || ovf)
      begin
        ovf <= 1'b1;                      // ignore rest of frame
      end
      else
      begin
        spec_ptr <= spec_ptr + 1'b1;
      end
    end
  end

  // errored last word may land here, rewind discards it
  always_ff @(posedge clk_125)
  begin
    if (wr_en)
    begin
      mem[spec_ptr[ADDR_W-1:0]] <= wr_word.word;
    end
  end

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  always_ff @(posedge clk_125)
  begin
    if (rst)
    begin
      rd_ptr <= '0;
    end
    else if (rd_en)
    begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // only committed words are served, head held until taken
  assign mac_rx_valid = rd_ptr != cmt_ptr;
  assign mac_rx_word  = mem[rd_ptr[ADDR_W-1:0]];

  // writer never laps the reader
  a_no_overrun: assert property (@(posedge clk_125) disable iff (rst)
    (spec_ptr - rd_ptr) <= DEPTH_P);

  // stalled beat holds across cycles
  a_rx_stable: assert property (@(posedge clk_125) disable iff (rst)
    mac_rx_valid && !mac_rx_ready |=> mac_rx_valid && $stable(mac_rx_word));

endmodule

`default_nettype wire

// File: src/tx_word_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_word_serializer
  import mac_byte_pkg::*, client_word_pkg::*;
(
  input  wire logic         clk_125,
  input  wire logic         rst,
  input  wire logic         mac_tx_valid,
  input  wire client_word_t mac_tx_word,
  output logic              mac_tx_ready,   // high while no word held
  output logic              tx_byte_valid,
  output mac_byte_t         tx_byte,
  input  wire logic         tx_byte_ready
);

  ////////////////////////////////////////
  // held word and lane stepper
  ////////////////////////////////////////

  client_word_t      held;                  // word being sent
  logic              busy;                  // held word has bytes left
  logic [LANE_W-1:0] lane_idx;              // lane on the mac bus now
  logic [LANE_W-1:0] lane_nxt;              // wraps past top lane
  logic              final_lane;            // no kept lane after this one
  logic              byte_xfer;

  assign lane_nxt   = lane_idx + 1'b1;
  // at top lane lane_nxt wraps to 0, first term covers it
  assign final_lane = (lane_idx == LAST_LANE) || !held.keep[lane_nxt];
  assign byte_xfer  = tx_byte_valid && tx_byte_ready;

  assign mac_tx_ready  = !busy;
  assign tx_byte_valid = busy;
  assign tx_byte.data  = held.data.lane[lane_idx];  // byte view of union
  assign tx_byte.last  = held.last && final_lane;

  always_ff @(posedge clk_125)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      lane_idx <= '0;
    end
    else if (mac_tx_valid && mac_tx_ready)
    begin
      busy     <= 1'b1;
      lane_idx <= '0;                       // keep starts at lane 0
    end
    else if (byte_xfer)
    begin
      if (final_lane)
      begin
        busy <= 1'b0;                       // ready again next cycle
      end
      else
      begin
        lane_idx <= lane_nxt;
      end
    end
  end

  always_ff @(posedge clk_125)
  begin
    if (mac_tx_valid && mac_tx_ready)
    begin
      held <= mac_tx_word;
    end
  end

  // lane stepper relies on keep filled from lane 0
  a_tx_keep: assert property (@(posedge clk_125) disable iff (rst)
    mac_tx_valid && mac_tx_ready |-> keep_contig(mac_tx_word.keep));

endmodule

`default_nettype wire

// File: src/mac_client_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module mac_client_bridge
  import mac_byte_pkg::*, client_word_pkg::*;
#(
  parameter int BUFFER_DEPTH = 16          // rx frame store, words
)
(
  input  wire logic         clk_125,
  input  wire logic         rst,
  // mac receive bytes
  input  wire logic         rx_byte_valid,
  input  wire mac_byte_t    rx_byte,
  input  wire logic         rx_frame_error,
  // user receive words
  output logic              mac_rx_valid,
  output client_word_t      mac_rx_word,
  input  wire logic         mac_rx_ready,
  // user transmit words
  input  wire logic         mac_tx_valid,
  input  wire client_word_t mac_tx_word,
  output logic              mac_tx_ready,
  // mac transmit bytes
  output logic              tx_byte_valid,
  output mac_byte_t         tx_byte,
  input  wire logic         tx_byte_ready
);

  ////////////////////////////////////////
  // receive path
  ////////////////////////////////////////

  logic     wr_valid;                      // packer to buffer strobe
  rx_word_t wr_word;

  rx_byte_packer u_rx_byte_packer (
    .clk_125        (clk_125),
    .rst            (rst),
    .rx_byte_valid  (rx_byte_valid),
    .rx_byte        (rx_byte),
    .rx_frame_error (rx_frame_error),
    .wr_valid       (wr_valid),
    .wr_word        (wr_word)
  );

  rx_frame_buffer #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) u_rx_frame_buffer (
    .clk_125      (clk_125),
    .rst          (rst),
    .wr_valid     (wr_valid),
    .wr_word      (wr_word),
    .mac_rx_valid (mac_rx_valid),
    .mac_rx_word  (mac_rx_word),
    .mac_rx_ready (mac_rx_ready)
  );

  ////////////////////////////////////////
  // transmit path
  ////////////////////////////////////////

  tx_word_serializer u_tx_word_serializer (
    .clk_125       (clk_125),
    .rst           (rst),
    .mac_tx_valid  (mac_tx_valid),
    .mac_tx_word   (mac_tx_word),
    .mac_tx_ready  (mac_tx_ready),
    .tx_byte_valid (tx_byte_valid),
    .tx_byte       (tx_byte),
    .tx_byte_ready (tx_byte_ready)
  );

endmodule

`default_nettype wire

// File: verification/tb_mac_client_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_client_bridge
  import mac_byte_pkg::*, client_word_pkg::*;
();

  localparam int STORE_WORDS  = 16;                                 // rx buffer depth in dut
  localparam int OVERSIZE_LEN = (STORE_WORDS + 2) * BYTES_PER_WORD + 3;  // runs past a full buffer
  localparam int RX_BYTES     = 3 * 20 * 40 + OVERSIZE_LEN + 16;    // worst case of tests 1 to 4
  localparam int TX_BYTES     = 30 * BYTES_PER_WORD;                // test 5 with all lanes kept
  localparam int CYCLE_LIMIT  = (RX_BYTES + TX_BYTES) * 4 + 2000;

  logic         clk_125;
  logic         rst;
  logic         rx_byte_valid;
  mac_byte_t    rx_byte;
  logic         rx_frame_error;
  logic         mac_rx_valid;
  client_word_t mac_rx_word;
  logic         mac_rx_ready;
  logic         mac_tx_valid;
  client_word_t mac_tx_word;
  logic         mac_tx_ready;
  logic         tx_byte_valid;
  mac_byte_t    tx_byte;
  logic         tx_byte_ready;

  client_word_t rx_exp_q[$];       // good words still owed to user side
  mac_byte_t    tx_exp_q[$];       // bytes of accepted tx words
  client_word_t tx_send_q[$];      // user words not yet accepted
  client_word_t hold_word;         // rx beat stalled last cycle
  logic         hold_pending;
  int           rx_rdy_mode;       // user ready low (0), high (1) or random (2)
  logic         tx_rdy_rand;
  integer       seed;
  int           errors;
  int           checks;
  int           err_start;
  int           cycles = 0;
  string        test_name;

  mac_client_bridge i_dut (.*);

  initial clk_125 = 1'b0;
  always #10 clk_125 = ~clk_125;   // 20 ns period

  always @(posedge clk_125)
  begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // random helpers on one shared seed
  ////////////////////////////////////////

  function automatic logic rand_bit();
    integer r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic logic [31:0] rand_u32();
    integer r;
    r = $random(seed);
    return r;
  endfunction

  function automatic int rand_range(int lo, int hi);
    integer r;
    r = $random(seed) & 32'h7fff_ffff;   // keep it positive
    return lo + r % (hi - lo + 1);
  endfunction

  ////////////////////////////////////////
  // one clock of stimulus and checking
  ////////////////////////////////////////

  // tx model expands kept lanes in order with last on the final kept byte
  task automatic expect_bytes(input client_word_t w);
    mac_byte_t b;
    int        n;
    n = 0;
    for (int i = 0; i < BYTES_PER_WORD; i++)
    begin
      if (w.keep[i])
      begin
        n++;
      end
    end
    for (int i = 0; i < n; i++)
    begin
      b.data = w.data.flat[i*BYTE_W +: BYTE_W];
      b.last = w.last && (i == n - 1);
      tx_exp_q.push_back(b);
    end
  endtask

  // outputs come from registers only, so values read here hold until posedge
  task automatic drive_cycle(input logic bv, input logic [BYTE_W-1:0] d, input logic l,
                             input logic err);
    client_word_t exp_w;
    mac_byte_t    exp_b;
    logic         tx_busy_exp;
    @(negedge clk_125);
    rx_byte_valid  = bv;
    rx_byte.data   = d;
    rx_byte.last   = l;
    rx_frame_error = err;
    mac_rx_ready   = (rx_rdy_mode == 2) ? rand_bit() : (rx_rdy_mode == 1);
    tx_byte_ready  = tx_rdy_rand ? rand_bit() : 1'b1;
    mac_tx_valid   = tx_send_q.size() > 0;
    mac_tx_word    = mac_tx_valid ? tx_send_q[0] : '0;
    if (hold_pending)                                    // stalled beat must hold
    begin
      checks++;
      if (!mac_rx_valid)
      begin
        $display("%s: rx valid dropped while the user side stalled", test_name);
        errors++;
      end
      else if (mac_rx_word !== hold_word)
      begin
        $display("FAIL %s: stalled rx word expected %h actual %h",
                 test_name, hold_word, mac_rx_word);
        errors++;
      end
    end
    hold_pending = mac_rx_valid && !mac_rx_ready;
    hold_word    = mac_rx_word;
    if (mac_rx_valid && mac_rx_ready)                    // rx word transfers at posedge
    begin
      checks++;
      if (rx_exp_q.size() == 0)
      begin
        $display("%s: rx word %h came out with none expected", test_name, mac_rx_word);
        errors++;
      end
      else
      begin
        exp_w = rx_exp_q.pop_front();
        if (mac_rx_word !== exp_w)
        begin
          $display("FAIL %s: rx word expected %h actual %h", test_name, exp_w, mac_rx_word);
          errors++;
        end
      end
    end
    tx_busy_exp = tx_exp_q.size() > 0;                   // held word still has bytes
    checks++;
    if (mac_tx_ready !== !tx_busy_exp || tx_byte_valid !== tx_busy_exp)
    begin
      $display("FAIL %s: tx ready and valid expected %b%b actual %b%b", test_name,
               !tx_busy_exp, tx_busy_exp, mac_tx_ready, tx_byte_valid);
      errors++;
    end
    if (mac_tx_valid && mac_tx_ready)                    // word accepted
    begin
      expect_bytes(tx_send_q.pop_front());
    end
    if (tx_byte_valid && tx_byte_ready)                  // byte transfers at posedge
    begin
      checks++;
      if (tx_exp_q.size() == 0)
      begin
        $display("%s: tx byte %h came out with none expected", test_name, tx_byte);
        errors++;
      end
      else
      begin
        exp_b = tx_exp_q.pop_front();
        if (tx_byte !== exp_b)
        begin
          $display("FAIL %s: tx byte expected %h actual %h", test_name, exp_b, tx_byte);
          errors++;
        end
      end
    end
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, 1'b0, 1'b0);
  endtask

  // rx model packs bytes from lane 0 and queues words of kept frames
  task automatic send_frame(input int len, input logic err, input int gap,
                            input logic expect_out);
    client_word_t      w;
    logic [31:0]       v;
    int                lane;
    w = '0;
    for (int i = 0; i < len; i++)
    begin
      v    = rand_u32();
      lane = i % BYTES_PER_WORD;
      w.data.flat[lane*BYTE_W +: BYTE_W] = v[7:0];
      w.keep[lane] = 1'b1;
      if (i == len - 1)
      begin
        drive_cycle(1'b1, v[7:0], 1'b1, err);
      end
      else
      begin
        drive_cycle(1'b1, v[7:0], 1'b0, rand_bit());    // flag is noise before last
      end
      if (lane == BYTES_PER_WORD - 1 || i == len - 1)
      begin
        w.last = (i == len - 1);
        if (expect_out && !err)
        begin
          rx_exp_q.push_back(w);
        end
        w = '0;                                          // unkept lanes stay zero
      end
    end
    repeat (gap) idle_cycle();
  endtask

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while ((rx_exp_q.size() > 0 || tx_exp_q.size() > 0 || tx_send_q.size() > 0)
           && n < max_cycles)
    begin
      idle_cycle();
      n++;
    end
    if (rx_exp_q.size() > 0 || tx_exp_q.size() > 0 || tx_send_q.size() > 0)
    begin
      $display("%s: %0d rx words, %0d tx bytes and %0d tx words never came out",
               test_name, rx_exp_q.size(), tx_exp_q.size(), tx_send_q.size());
      errors++;
    end
    repeat (4) idle_cycle();                             // stray beats get flagged
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", test_name, errors - err_start);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial
  begin
    client_word_t w;
    seed           = 32'h57bb;
    rst            = 1'b1;
    rx_byte_valid  = 1'b0;
    rx_byte        = '0;
    rx_frame_error = 1'b0;
    mac_rx_ready   = 1'b0;
    mac_tx_valid   = 1'b0;
    mac_tx_word    = '0;
    tx_byte_ready  = 1'b0;
    rx_rdy_mode    = 1;
    tx_rdy_rand    = 1'b0;
    hold_pending   = 1'b0;
    hold_word      = '0;
    errors         = 0;
    checks         = 0;
    repeat (3) @(negedge clk_125);                       // three reset edges
    rst = 1'b0;
    if (mac_rx_valid || tx_byte_valid || !mac_tx_ready)
    begin
      $display("reset: outputs not at their idle values after reset");
      errors++;
    end

    begin_test("good_frames");
    repeat (20) send_frame(rand_range(1, 40), 1'b0, 1, 1'b1);
    drain(2000);
    end_test();

    begin_test("errored_frames");
    repeat (20) send_frame(rand_range(1, 40), rand_range(0, 2) == 0, 1, 1'b1);
    drain(2000);
    end_test();

    begin_test("rx_backpressure");
    rx_rdy_mode = 2;
    repeat (20) send_frame(rand_range(1, 40), 1'b0, 2, 1'b1);
    drain(2000);
    end_test();

    begin_test("oversize_frame");
    rx_rdy_mode = 0;                                     // buffer cannot drain
    send_frame(OVERSIZE_LEN, 1'b0, 4, 1'b0);
    if (mac_rx_valid)
    begin
      $display("%s: words of the oversize frame became visible", test_name);
      errors++;
    end
    rx_rdy_mode = 1;
    send_frame(rand_range(1, 16), 1'b0, 1, 1'b1);
    drain(2000);
    end_test();

    begin_test("tx_split");
    tx_rdy_rand = 1'b1;
    repeat (30)
    begin
      w.data.flat = {rand_u32(), rand_u32()};
      w.keep      = BYTES_PER_WORD'((1 << rand_range(1, BYTES_PER_WORD)) - 1);
      w.last      = rand_bit();
      tx_send_q.push_back(w);
    end
    drain(2000);
    end_test();

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
src/mac_byte_pkg.sv
src/client_word_pkg.sv
src/rx_byte_packer.sv
src/rx_frame_buffer.sv
src/tx_word_serializer.sv
src/mac_client_bridge.sv
verification/tb_mac_client_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the bridge testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_mac_client_bridge \
  -f project.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
  exit 0
fi
exit 1
